// ==== src.f ====
+incdir+include
source/ring_pkg.sv
source/tile_pkg.sv
source/msgFifo.sv
source/ringStop.sv
source/memTile.sv
source/hostTile.sv
source/lotrRing.sv
tb/lotrRing_asserts.sv
tb/lotrRing_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ring testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module lotrRing_tb -o lotrRing_sim
./obj_dir/lotrRing_sim

// ==== tb/lotrRing_tb.sv ====
`timescale 1ns/10ps
`include "ring_settings.svh"

module lotrRing_tb
    import ring_pkg::*;
    import tile_pkg::*;
();

    localparam int LIMIT    = 3000;              // cycles allowed per wait
    localparam int TAGS     = 1 << `RING_TAG_W;
    localparam int NUM_STIM = 18;

    typedef struct packed {
        ringOpcodeT  op;
        logic [7:0]  tile;      // upper address byte
        logic [3:0]  word;      // low address bits
        logic [31:0] data;
        logic        waitRsp;   // hold the next entry until this one is answered
    } stimT;

    // op, tile, word, data, wait
    localparam stimT STIM [NUM_STIM] = '{
        '{WR, 8'd1, 4'd3, 32'h1111_0001, 1'b1},
        '{RD, 8'd1, 4'd3, 32'h0000_0000, 1'b1},
        '{WR, 8'd2, 4'd3, 32'h2222_0002, 1'b1},
        '{RD, 8'd2, 4'd3, 32'h0000_0000, 1'b1},
        '{WR, 8'd3, 4'd3, 32'h3333_0003, 1'b1},
        '{RD, 8'd3, 4'd3, 32'h0000_0000, 1'b1},
        '{RD, 8'd1, 4'd3, 32'h0000_0000, 1'b1},  // tile 1 kept its own word
        '{WR, 8'd1, 4'd9, 32'hA5A5_1009, 1'b1},
        '{WR, 8'd2, 4'd9, 32'h5A5A_2009, 1'b1},
        '{WR, 8'd3, 4'd9, 32'hC3C3_3009, 1'b1},
        // burst over all tiles, nothing waited for
        '{RD, 8'd3, 4'd9, 32'h0000_0000, 1'b0},
        '{RD, 8'd1, 4'd9, 32'h0000_0000, 1'b0},
        '{RD, 8'd2, 4'd3, 32'h0000_0000, 1'b0},
        '{RD, 8'd3, 4'd3, 32'h0000_0000, 1'b0},
        '{RD, 8'd2, 4'd9, 32'h0000_0000, 1'b0},
        '{RD, 8'd1, 4'd3, 32'h0000_0000, 1'b0},
        '{WR, 8'd2, 4'd15, 32'hDEAD_BEEF, 1'b0},
        '{RD, 8'd3, 4'd9, 32'h0000_0000, 1'b0}
    };

    logic        QClk;
    logic        rst;
    logic        reqValid;
    logic        reqReady;
    hostReqT     req;
    logic        rspValid;
    logic        rspReady;
    hostRspT     rsp;

    logic [31:0] refMem [256][16];   // reference words by tile and word
    ringOpcodeT  expOp   [TAGS];
    logic [31:0] expData [TAGS];
    int          issued  [TAGS];     // requests sent per tag
    int          answered[TAGS];     // responses taken per tag
    tagT         nextTag;
    int          seed    = 32'h1b2a;
    int          lowLeft = 0;        // cycles left in a long stall
    logic        holdRsp = 1'b0;     // keeps rspReady low while set
    logic [31:0] rnd;

    lotrRing u_lotrRing (
        .QClk     (QClk),
        .rst      (rst),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .req      (req),
        .rspValid (rspValid),
        .rspReady (rspReady),
        .rsp      (rsp)
    );

    // ======================================================================
    // helpers
    // ======================================================================

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic waitResponse(input tagT tag);
        int waitCnt;
        waitCnt = 0;
        while (issued[tag] != answered[tag]) begin
            @(negedge QClk);
            waitCnt++;
            if (waitCnt > LIMIT) abortRun($sformatf("no response for tag %0d within limit", tag));
        end
    endtask

    task automatic issueRequest(input stimT s);
        int  waitCnt;
        tagT tag;
        tag = nextTag;
        waitResponse(tag);                       // tag must be free before reuse
        if (s.op == WR) begin
            refMem[s.tile][s.word] = s.data;     // updated in table order
            expOp[tag]   = WR_RSP;
            expData[tag] = s.data;
        end else begin
            expOp[tag]   = RD_RSP;
            expData[tag] = refMem[s.tile][s.word];
        end
        issued[tag]++;
        req.opcode  = s.op;
        req.address = {s.tile, 20'h0_0000, s.word};
        req.data    = s.data;
        req.tag     = tag;
        reqValid    = 1'b1;
        waitCnt     = 0;
        while (!reqReady) begin
            @(negedge QClk);
            waitCnt++;
            if (waitCnt > LIMIT) abortRun("request queue never accepted the request");
        end
        @(negedge QClk);                         // taken on the edge just passed
        reqValid = 1'b0;
        nextTag  = tag + tagT'(1);
        if (s.waitRsp) waitResponse(tag);
    endtask

    // ======================================================================
    // clock, response side, main sequence
    // ======================================================================

    initial begin
        QClk = 1'b0;
        forever #50 QClk = ~QClk;
    end

    // random rspReady with occasional long stalls, takes answers by tag
    initial begin
        rspReady = 1'b0;
        forever begin
            @(negedge QClk);
            if (rst || holdRsp) begin
                rspReady = 1'b0;
            end else if (lowLeft > 0) begin
                rspReady = 1'b0;
                lowLeft--;
            end else begin
                rnd = $random(seed);
                if (rnd[5:0] == 6'd0) lowLeft = 20 + int'(rnd[11:8]);
                rspReady = (rnd[2:0] != 3'd0);   // mostly ready
            end
            if (!rst && rspValid && rspReady) begin
                if (answered[rsp.tag] == issued[rsp.tag])
                    abortRun($sformatf("response for tag %0d that is not outstanding", rsp.tag));
                checkValue("rsp.opcode", 32'(rsp.opcode), 32'(expOp[rsp.tag]));
                checkValue("rsp.data", rsp.data, expData[rsp.tag]);
                answered[rsp.tag]++;
            end
        end
    end

    initial begin : mainSeq
        int waitCnt;
        rst      = 1'b1;
        reqValid = 1'b0;
        req      = '0;
        nextTag  = '0;
        waitCnt  = 0;
        repeat (8) @(posedge QClk);
        @(negedge QClk);
        rst = 1'b0;
        checkValue("rspValid", 32'(rspValid), 32'h0);
        while (!reqReady) begin
            @(negedge QClk);
            waitCnt++;
            if (waitCnt > LIMIT) abortRun("reqReady did not rise after reset");
        end
        for (int i = 0; i < NUM_STIM; i++) begin
            holdRsp = !STIM[i].waitRsp;          // burst answers pile up at the host
            issueRequest(STIM[i]);
        end
        repeat (40) @(negedge QClk);             // host queue full, the rest circling
        holdRsp = 1'b0;
        for (int t = 0; t < TAGS; t++) waitResponse(tagT'(t));   // drain
        repeat (20) begin                        // nothing extra may come back
            @(negedge QClk);
            if (rspValid) abortRun("response arrived with nothing outstanding");
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== tb/lotrRing_asserts.sv ====
`timescale 1ns/10ps
`include "ring_settings.svh"

module lotrRing_asserts
    import ring_pkg::*;
    import tile_pkg::*;
(
    input logic    QClk,
    input logic    rst,
    input logic    rspValid,
    input logic    rspReady,
    input hostRspT rsp,
    input ringMsgT reqRing [`RING_NUM_MEM_TILES + 1]
);

    localparam int NUM_MEM = `RING_NUM_MEM_TILES;

    // every request slot names an existing memory tile
    for (genvar k = 0; k <= NUM_MEM; k++) begin : genDestCheck
        reqDestInRange: assert property (@(posedge QClk) disable iff (rst)
            reqRing[k].valid |->
                (reqRing[k].dest != HOST_ID && reqRing[k].dest <= tileIdT'(NUM_MEM)))
            else $error("reqRing[%0d] carries dest %0d", k, reqRing[k].dest);
    end

    // answer held until the host takes it
    rspHeld: assert property (@(posedge QClk) disable iff (rst)
        (rspValid && !rspReady) |=> $stable(rsp))
        else $error("rsp changed while rspReady was low");

    rspLowAfterReset: assert property (@(posedge QClk) rst |=> !rspValid)
        else $error("rspValid high in the cycle after reset");

endmodule

bind lotrRing lotrRing_asserts u_lotrRingAsserts (
    .QClk     (QClk),
    .rst      (rst),
    .rspValid (rspValid),
    .rspReady (rspReady),
    .rsp      (rsp),
    .reqRing  (reqRing)
);

// ==== source/lotrRing.sv ====
`timescale 1ns/10ps
`include "ring_settings.svh"

module lotrRing
    import ring_pkg::*;
    import tile_pkg::*;
(
    input  logic    QClk,
    input  logic    rst,
    input  logic    reqValid,
    output logic    reqReady,
    input  hostReqT req,
    output logic    rspValid,
    input  logic    rspReady,
    output hostRspT rsp
);

    localparam int NUM_MEM = `RING_NUM_MEM_TILES;

    // index k is driven by tile k, tile k listens on k-1
    ringMsgT reqRing [NUM_MEM + 1];
    ringMsgT rspRing [NUM_MEM + 1];

    // ======================================================================
    // host tile closes both rings
    // ======================================================================

    hostTile u_hostTile (
        .QClk     (QClk),
        .rst      (rst),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .req      (req),
        .rspValid (rspValid),
        .rspReady (rspReady),
        .rsp      (rsp),
        .reqIn    (reqRing[NUM_MEM]),   // wrap from the last tile
        .reqOut   (reqRing[0]),
        .rspIn    (rspRing[NUM_MEM]),
        .rspOut   (rspRing[0])
    );

    // ======================================================================
    // memory tiles 1 .. NUM_MEM
    // ======================================================================

    for (genvar k = 1; k <= NUM_MEM; k++) begin : genMemTile
        memTile #(.TILE_ID(tileIdT'(k))) u_memTile (
            .QClk   (QClk),
            .rst    (rst),
            .reqIn  (reqRing[k-1]),
            .reqOut (reqRing[k]),
            .rspIn  (rspRing[k-1]),
            .rspOut (rspRing[k])
        );
    end

endmodule

// ==== source/hostTile.sv ====
`timescale 1ns/10ps

module hostTile
    import ring_pkg::*;
    import tile_pkg::*;
(
    input  logic    QClk,
    input  logic    rst,
    // host port
    input  logic    reqValid,
    output logic    reqReady,
    input  hostReqT req,
    output logic    rspValid,
    input  logic    rspReady,
    output hostRspT rsp,
    // rings
    input  ringMsgT reqIn,
    output ringMsgT reqOut,
    input  ringMsgT rspIn,
    output ringMsgT rspOut
);

    hostReqT reqQData;
    logic    reqQValid;
    logic    reqQReady;  // slot free on the req ring
    ringMsgT reqMsg;
    ringMsgT rspMsg;
    logic    ejValid;
    logic    ejReady;
    hostRspT rspStrip;

    // ======================================================================
    // request path, host port -> queue -> req ring
    // ======================================================================

    msgFifo #(.payloadT(hostReqT)) u_reqFifo (
        .QClk     (QClk),
        .rst      (rst),
        .inValid  (reqValid),
        .inReady  (reqReady),   // low when full
        .inData   (req),
        .outValid (reqQValid),
        .outReady (reqQReady),
        .outData  (reqQData)
    );

    always_comb begin
        reqMsg.valid   = 1'b1;
        reqMsg.dest    = reqQData.address[31:24]; // no range check here
        reqMsg.src     = HOST_ID;
        reqMsg.tag     = reqQData.tag;
        reqMsg.opcode  = reqQData.opcode;
        reqMsg.address = reqQData.address;
        reqMsg.data    = reqQData.data;
    end

    ringStop #(.TILE_ID(HOST_ID)) u_reqStop (
        .QClk        (QClk),
        .rst         (rst),
        .ringIn      (reqIn),
        .ringOut     (reqOut),
        .ejectValid  (),
        .ejectReady  (1'b0),
        .ejectMsg    (),
        .injectValid (reqQValid),
        .injectReady (reqQReady),
        .injectMsg   (reqMsg)
    );

    // ======================================================================
    // response path, rsp ring -> queue -> host port
    // ======================================================================

    ringStop #(.TILE_ID(HOST_ID)) u_rspStop (
        .QClk        (QClk),
        .rst         (rst),
        .ringIn      (rspIn),
        .ringOut     (rspOut),
        .ejectValid  (ejValid),
        .ejectReady  (ejReady), // full queue keeps answers circling
        .ejectMsg    (rspMsg),
        .injectValid (1'b0),
        .injectReady (),
        .injectMsg   ('0)
    );

    // drop the routing fields
    assign rspStrip.opcode = rspMsg.opcode;
    assign rspStrip.data   = rspMsg.data;
    assign rspStrip.tag    = rspMsg.tag;

    msgFifo #(.payloadT(hostRspT)) u_rspFifo (
        .QClk     (QClk),
        .rst      (rst),
        .inValid  (ejValid),
        .inReady  (ejReady),
        .inData   (rspStrip),
        .outValid (rspValid),
        .outReady (rspReady),
        .outData  (rsp)
    );

endmodule

// ==== source/memTile.sv ====
`timescale 1ns/10ps
`include "ring_settings.svh"

module memTile
    import ring_pkg::*;
#(
    parameter tileIdT TILE_ID = 8'd1
) (
    input  logic    QClk,
    input  logic    rst,
    input  ringMsgT reqIn,
    output ringMsgT reqOut,
    input  ringMsgT rspIn,
    output ringMsgT rspOut
);

    localparam int MEM_DEPTH = `RING_MEM_DEPTH;
    localparam int WORD_W    = $clog2(MEM_DEPTH);

    logic [31:0]       mem [MEM_DEPTH];
    ringMsgT           reqMsg;     // request leaving the req ring
    ringMsgT           rspMsg;     // answer built from it
    ringMsgT           rspQData;
    logic              ejValid;
    logic              ejReady;    // response queue has room
    logic              rspQValid;
    logic              rspQReady;
    logic              reqFire;
    logic              memWrite;
    logic [WORD_W-1:0] wordIdx;

    // ======================================================================
    // request ring, eject only when the answer can be queued
    // ======================================================================

    ringStop #(.TILE_ID(TILE_ID)) u_reqStop (
        .QClk        (QClk),
        .rst         (rst),
        .ringIn      (reqIn),
        .ringOut     (reqOut),
        .ejectValid  (ejValid),
        .ejectReady  (ejReady),
        .ejectMsg    (reqMsg),
        .injectValid (1'b0),    // memory tiles never issue requests
        .injectReady (),
        .injectMsg   ('0)
    );

    assign wordIdx  = reqMsg.address[WORD_W-1:0];   // word index, not byte
    assign reqFire  = ejValid && ejReady;
    assign memWrite = reqFire && (reqMsg.opcode == WR);

    always_ff @(posedge QClk) begin
        if (memWrite) mem[wordIdx] <= reqMsg.data;
    end

    // answer goes back to whoever asked
    always_comb begin
        rspMsg         = reqMsg;
        rspMsg.valid   = 1'b1;
        rspMsg.dest    = reqMsg.src;
        rspMsg.src     = TILE_ID;
        rspMsg.opcode  = (reqMsg.opcode == WR) ? WR_RSP : RD_RSP;
        rspMsg.data    = (reqMsg.opcode == WR) ? reqMsg.data : mem[wordIdx];
    end

    msgFifo #(.payloadT(ringMsgT)) u_rspFifo (
        .QClk     (QClk),
        .rst      (rst),
        .inValid  (ejValid),    // queued on the ejection edge
        .inReady  (ejReady),
        .inData   (rspMsg),
        .outValid (rspQValid),
        .outReady (rspQReady),
        .outData  (rspQData)
    );

    // ======================================================================
    // response ring, inject only
    // ======================================================================

    ringStop #(.TILE_ID(TILE_ID)) u_rspStop (
        .QClk        (QClk),
        .rst         (rst),
        .ringIn      (rspIn),
        .ringOut     (rspOut),
        .ejectValid  (),
        .ejectReady  (1'b0),    // no response is ever addressed here
        .ejectMsg    (),
        .injectValid (rspQValid),
        .injectReady (rspQReady),
        .injectMsg   (rspQData)
    );

endmodule

// ==== source/ringStop.sv ====
`timescale 1ns/10ps

module ringStop
    import ring_pkg::*;
#(
    parameter tileIdT TILE_ID = 8'd0
) (
    input  logic    QClk,
    input  logic    rst,
    // ring side
    input  ringMsgT ringIn,
    output ringMsgT ringOut,
    // toward the tile
    output logic    ejectValid,
    input  logic    ejectReady,
    output ringMsgT ejectMsg,
    // from the tile
    input  logic    injectValid,
    output logic    injectReady,
    input  ringMsgT injectMsg
);

    ringMsgT slotQ;     // hop register, one clock per stop
    ringMsgT slotNext;
    logic    destHit;
    logic    ejectFire;
    logic    slotFree;

    // ======================================================================
    // eject decision
    // ======================================================================

    assign destHit    = ringIn.valid && (ringIn.dest == TILE_ID);
    assign ejectValid = destHit;
    assign ejectMsg   = ringIn;
    assign ejectFire  = destHit && ejectReady; // no room leaves it circling

    // outgoing slot is free if nothing came in or it was just taken off
    assign slotFree    = !ringIn.valid || ejectFire;
    assign injectReady = slotFree;

    // ======================================================================
    // next slot
    // ======================================================================

    always_comb begin
        slotNext = ringIn; // forward unchanged
        if (slotFree) begin
            slotNext       = injectMsg;
            slotNext.valid = injectValid; // empty slot unless the tile offers one
        end
    end

    // only the valid bit needs clearing, payload is don't care when empty
    always_ff @(posedge QClk) begin
        if (rst) begin
            slotQ.valid <= 1'b0;
        end else begin
            slotQ <= slotNext;
        end
    end

    assign ringOut = slotQ;

endmodule

// ==== source/msgFifo.sv ====
`timescale 1ns/10ps
`include "ring_settings.svh"

module msgFifo #(
    parameter type payloadT = logic
) (
    input  logic    QClk,
    input  logic    rst,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    localparam int DEPTH = `RING_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payloadT          mem [DEPTH];  // storage, no reset needed
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;        // entries held
    logic             pushEn;
    logic             popEn;

    // wrap at DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign inReady  = (count != CNT_W'(DEPTH)); // not full
    assign outValid = (count != '0);            // not empty
    assign outData  = mem[rdPtr];               // head always visible
    assign pushEn   = inValid && inReady;
    assign popEn    = outValid && outReady;

    always_ff @(posedge QClk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushEn) wrPtr <= nextPtr(wrPtr);
            if (popEn)  rdPtr <= nextPtr(rdPtr);
            case ({pushEn, popEn})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count; // both or neither, level unchanged
            endcase
        end
    end

    always_ff @(posedge QClk) begin
        if (pushEn) mem[wrPtr] <= inData;
    end

endmodule

// ==== source/tile_pkg.sv ====
package tile_pkg;
    import ring_pkg::*;

    // ======================================================================
    // host port payloads
    // ======================================================================

    // request as the host hands it over
    typedef struct packed {
        ringOpcodeT  opcode;  // RD or WR
        logic [31:0] address; // [31:24] selects the tile
        logic [31:0] data;    // write data, don't care on RD
        tagT         tag;
    } hostReqT;

    // answer returned to the host, ring routing fields stripped
    typedef struct packed {
        ringOpcodeT  opcode;  // RD_RSP or WR_RSP
        logic [31:0] data;    // read word or echoed write data
        tagT         tag;     // copied from the request
    } hostRspT;

endpackage

// ==== source/ring_pkg.sv ====
`include "ring_settings.svh"

package ring_pkg;

    // ======================================================================
    // on-ring message format
    // ======================================================================

    typedef logic [7:0]             tileIdT;  // tile number, 0 is the host
    typedef logic [`RING_TAG_W-1:0] tagT;     // pairs a response with its request

    localparam tileIdT HOST_ID = 8'd0;

    // requests travel on the req ring, answers on the rsp ring
    typedef enum logic [1:0] {
        RD     = 2'b00,
        WR     = 2'b01,
        RD_RSP = 2'b10,
        WR_RSP = 2'b11
    } ringOpcodeT;

    // one ring slot, same layout on both rings
    typedef struct packed {
        logic        valid;   // slot occupied
        tileIdT      dest;    // tile that ejects it
        tileIdT      src;     // tile that sent it
        tagT         tag;
        ringOpcodeT  opcode;
        logic [31:0] address; // upper byte is the tile
        logic [31:0] data;
    } ringMsgT;

endpackage

// ==== include/ring_settings.svh ====
`ifndef RING_SETTINGS_SVH
`define RING_SETTINGS_SVH

// ==========================================================================
// ring sizing
// ==========================================================================

// memory tiles on the ring, tile 0 is the host
`define RING_NUM_MEM_TILES 3

// words held by each memory tile
`define RING_MEM_DEPTH 16

// entries per message queue
`define RING_FIFO_DEPTH 4

// request tag width, sets how many requests may be in flight
`define RING_TAG_W 4

`endif
